//--- source/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// First instruction fetched once the cache is ready
`define FETCH_RESET_VECTOR 32'h0000_0100

// Fetch restarts here after a misaligned or faulting fetch
`define FETCH_TRAP_VECTOR 32'h0000_0040

// Direct-mapped cache with one instruction word per line
`define CACHE_LINES 16

// Cycles spent in FILL before the line is written
`define CACHE_FILL_CYCLES 3

// Program memory depth in 32-bit words
// Byte addresses at or above 4 * MEM_WORDS fault
`define MEM_WORDS 256

`endif

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // Fetch unit to cache
    typedef enum logic [1:0] {
        CMD_NONE      = 2'd0,
        CMD_EXECUTE   = 2'd1,
        CMD_FLUSH_ALL = 2'd2
    } cache_cmd_e;

    // Cache to fetch unit, terminal codes last one cycle
    typedef enum logic [2:0] {
        RESP_IDLE        = 3'd0,
        RESP_WAIT        = 3'd1,
        RESP_DONE        = 3'd2,
        RESP_MISALIGNED  = 3'd3,
        RESP_ACCESSFAULT = 3'd4
    } cache_resp_e;

    // Error code seen by execute
    typedef enum logic [1:0] {
        ERR_NONE         = 2'd0,
        ERR_MISALIGNED   = 2'd1,
        ERR_ACCESS_FAULT = 2'd2
    } fetch_err_e;

    // Redirect requests from execute
    typedef enum logic [1:0] {
        E2F_NONE   = 2'd0,
        E2F_BRANCH = 2'd1,
        E2F_FLUSH  = 2'd2
    } e2f_cmd_e;

    typedef enum logic [2:0] {
        ST_SWEEP,
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_RESPOND
    } cache_state_e;

    // Instruction hand-off towards execute
    typedef struct packed {
        logic       valid;
        instr_t     instr;
        addr_t      pc;
        fetch_err_e error;
    } f2e_t;

    // Execute back to fetch
    typedef struct packed {
        logic     ready;
        e2f_cmd_e cmd;
        addr_t    target;
    } e2f_t;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // Cache interface
    input  cache_resp_e c_response,
    input  logic        c_reset_done,
    input  instr_t      c_load_data,
    output cache_cmd_e  c_cmd,
    output addr_t       c_address,
    // Execute interface
    input  e2f_t        e2f,
    output f2e_t        f2e
);

    // Address of the request in flight or last answered
    addr_t      pc;
    logic       bubble;
    logic       flushing;
    instr_t     saved_instr;
    // Error reported while execute was stalled
    fetch_err_e last_err;

    addr_t      pc_nxt;
    logic       bubble_nxt;
    logic       flushing_nxt;
    fetch_err_e last_err_nxt;

    fetch_err_e resp_err;
    logic       cache_done;
    logic       cache_idle;
    logic       cache_error;
    logic       new_fetch_begin;
    addr_t      pc_plus_4;

    // Response decode
    always_comb begin
        case (c_response)
            RESP_MISALIGNED:  resp_err = ERR_MISALIGNED;
            RESP_ACCESSFAULT: resp_err = ERR_ACCESS_FAULT;
            default:          resp_err = ERR_NONE;
        endcase
    end

    assign cache_done  = (c_response == RESP_DONE);
    assign cache_idle  = (c_response == RESP_IDLE);
    assign cache_error = (resp_err != ERR_NONE);

    // Execute can take something and the cache is free
    assign new_fetch_begin = e2f.ready && (cache_done || cache_idle || cache_error);

    assign pc_plus_4 = pc + 32'd4;

    // Cache latches the next PC together with the command
    assign c_address = pc_nxt;

    // Command and next-PC selection
    always_comb begin
        pc_nxt       = pc;
        bubble_nxt   = bubble;
        flushing_nxt = flushing;
        last_err_nxt = last_err;
        c_cmd        = CMD_NONE;
        // Nothing is issued until the invalidation sweep ends
        if (c_reset_done) begin
            if (flushing) begin
                // Flush started once the cache is idle, ends on DONE
                if (cache_done) begin
                    flushing_nxt = 1'b0;
                end else if (cache_idle) begin
                    c_cmd = CMD_FLUSH_ALL;
                end
            end else if (bubble) begin
                // Restart at pc after reset or flush
                if (cache_idle && e2f.ready) begin
                    c_cmd      = CMD_EXECUTE;
                    bubble_nxt = 1'b0;
                end
            end else if (new_fetch_begin) begin
                last_err_nxt = ERR_NONE;
                case (e2f.cmd)
                    E2F_BRANCH: begin
                        pc_nxt = e2f.target;
                        c_cmd  = CMD_EXECUTE;
                    end
                    E2F_FLUSH: begin
                        // Resume after the flush with one bubble
                        pc_nxt       = pc_plus_4;
                        bubble_nxt   = 1'b1;
                        flushing_nxt = 1'b1;
                    end
                    default: begin
                        // Current or pending error goes to the trap vector
                        if (cache_error || (last_err != ERR_NONE)) begin
                            pc_nxt = `FETCH_TRAP_VECTOR;
                        end else begin
                            pc_nxt = pc_plus_4;
                        end
                        c_cmd = CMD_EXECUTE;
                    end
                endcase
            end else if (cache_error) begin
                // Stalled execute, keep the error for the next fetch
                last_err_nxt = resp_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `FETCH_RESET_VECTOR;
            bubble   <= 1'b1;
            flushing <= 1'b0;
            last_err <= ERR_NONE;
        end else begin
            pc       <= pc_nxt;
            bubble   <= bubble_nxt;
            flushing <= flushing_nxt;
            last_err <= last_err_nxt;
        end
    end

    // Copy of the answered word, replayed under back-pressure
    always_ff @(posedge clk) begin
        if (cache_done && !flushing) begin
            saved_instr <= c_load_data;
        end
    end

    // Hand-off towards execute
    always_comb begin
        f2e.valid = 1'b0;
        f2e.instr = c_load_data;
        f2e.pc    = pc;
        // Shown only in the cycle the cache reports it
        f2e.error = resp_err;
        if (c_reset_done && !flushing) begin
            if (cache_done) begin
                f2e.valid = 1'b1;
            end else if (cache_idle && !bubble && (last_err == ERR_NONE)) begin
                // Word answered while ready was low
                f2e.valid = 1'b1;
                f2e.instr = saved_instr;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_cache
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // Fetch unit side
    input  cache_cmd_e  c_cmd,
    input  addr_t       c_address,
    output cache_resp_e c_response,
    output instr_t      c_load_data,
    output logic        c_reset_done,
    // Program memory side
    output logic        m_re,
    output addr_t       m_addr,
    input  instr_t      m_rdata
);

    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W  = 32 - IDX_W - 2;
    localparam int FILL_W = $clog2(`CACHE_FILL_CYCLES + 1);
    localparam addr_t MEM_LIMIT = addr_t'(`MEM_WORDS * 4);

    // Line storage
    logic [TAG_W-1:0]        tag_mem [`CACHE_LINES];
    instr_t                  data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;

    cache_state_e      state_q;
    cache_resp_e       resp_q;
    logic [IDX_W-1:0]  sweep_cnt;
    logic [FILL_W-1:0] fill_cnt;
    // Sweep was started by FLUSH_ALL and must answer DONE
    logic              flush_q;
    logic              reset_done_q;
    addr_t             addr_q;
    instr_t            data_q;

    logic             accept;
    logic             cmd_misaligned;
    logic             cmd_fault;
    logic [IDX_W-1:0] line_idx;
    logic [TAG_W-1:0] line_tag;
    logic             hit;
    logic             sweep_last;
    logic             fill_last;

    // A new command is taken in IDLE or while answering
    assign accept = (state_q == ST_IDLE) || (state_q == ST_RESPOND);

    assign cmd_misaligned = |c_address[1:0];
    assign cmd_fault      = (c_address >= MEM_LIMIT);

    assign line_idx = addr_q[IDX_W+1:2];
    assign line_tag = addr_q[31:IDX_W+2];
    assign hit      = valid_q[line_idx] && (tag_mem[line_idx] == line_tag);

    assign sweep_last = (sweep_cnt == IDX_W'(`CACHE_LINES - 1));
    assign fill_last  = (fill_cnt == FILL_W'(`CACHE_FILL_CYCLES - 1));

    // One memory read per miss
    assign m_re   = (state_q == ST_LOOKUP) && !hit;
    assign m_addr = addr_q;

    assign c_load_data  = data_q;
    assign c_reset_done = reset_done_q;

    always_comb begin
        case (state_q)
            ST_IDLE:    c_response = RESP_IDLE;
            ST_RESPOND: c_response = resp_q;
            default:    c_response = RESP_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ST_SWEEP;
            resp_q       <= RESP_IDLE;
            sweep_cnt    <= '0;
            fill_cnt     <= '0;
            flush_q      <= 1'b0;
            reset_done_q <= 1'b0;
        end else begin
            case (state_q)
                ST_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_last) begin
                        reset_done_q <= 1'b1;
                        flush_q      <= 1'b0;
                        resp_q       <= RESP_DONE;
                        state_q      <= flush_q ? ST_RESPOND : ST_IDLE;
                    end
                end
                ST_IDLE, ST_RESPOND: begin
                    if (c_cmd == CMD_EXECUTE) begin
                        // Bad addresses answer one cycle later
                        if (cmd_misaligned) begin
                            resp_q  <= RESP_MISALIGNED;
                            state_q <= ST_RESPOND;
                        end else if (cmd_fault) begin
                            resp_q  <= RESP_ACCESSFAULT;
                            state_q <= ST_RESPOND;
                        end else begin
                            state_q <= ST_LOOKUP;
                        end
                    end else if (c_cmd == CMD_FLUSH_ALL) begin
                        sweep_cnt <= '0;
                        flush_q   <= 1'b1;
                        state_q   <= ST_SWEEP;
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_LOOKUP: begin
                    fill_cnt <= '0;
                    if (hit) begin
                        resp_q  <= RESP_DONE;
                        state_q <= ST_RESPOND;
                    end else begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_last) begin
                        resp_q  <= RESP_DONE;
                        state_q <= ST_RESPOND;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Lines, tags, valid bits and the answer word
    always_ff @(posedge clk) begin
        if (accept && (c_cmd == CMD_EXECUTE)) begin
            addr_q <= c_address;
        end
        if (state_q == ST_SWEEP) begin
            valid_q[sweep_cnt] <= 1'b0;
        end
        if ((state_q == ST_LOOKUP) && hit) begin
            data_q <= data_mem[line_idx];
        end
        // Memory word has been stable since the cycle after m_re
        if ((state_q == ST_FILL) && fill_last) begin
            data_mem[line_idx] <= m_rdata;
            tag_mem[line_idx]  <= line_tag;
            valid_q[line_idx]  <= 1'b1;
            data_q             <= m_rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/prog_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module prog_mem
    import fetch_pkg::*;
(
    input  logic   clk,
    // Program load port
    input  logic   we,
    input  addr_t  waddr,
    input  instr_t wdata,
    // Read port, data one cycle after re
    input  logic   re,
    input  addr_t  raddr,
    output instr_t rdata
);

    localparam int AW = $clog2(`MEM_WORDS);
    localparam addr_t MEM_LIMIT = addr_t'(`MEM_WORDS * 4);

    instr_t mem [`MEM_WORDS];

    logic          w_in_range;
    logic [AW-1:0] w_word;
    logic [AW-1:0] r_word;

    // Byte address to word index
    assign w_word = waddr[AW+1:2];
    assign r_word = raddr[AW+1:2];

    // Loads past the end are dropped
    assign w_in_range = (waddr < MEM_LIMIT);

    always_ff @(posedge clk) begin
        if (we && w_in_range) begin
            mem[w_word] <= wdata;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[r_word];
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_subsys
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // Execute stage
    input  e2f_t   e2f,
    output f2e_t   f2e,
    // Program load
    input  logic   mem_we,
    input  addr_t  mem_waddr,
    input  instr_t mem_wdata
);

    // Fetch unit to cache
    cache_cmd_e  c_cmd;
    addr_t       c_address;
    cache_resp_e c_response;
    instr_t      c_load_data;
    logic        c_reset_done;

    // Cache to memory
    logic   m_re;
    addr_t  m_addr;
    instr_t m_rdata;

    fetch_unit i_fetch_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_response   (c_response),
        .c_reset_done (c_reset_done),
        .c_load_data  (c_load_data),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .e2f          (e2f),
        .f2e          (f2e)
    );

    fetch_cache i_fetch_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done),
        .m_re         (m_re),
        .m_addr       (m_addr),
        .m_rdata      (m_rdata)
    );

    prog_mem i_prog_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .re    (m_re),
        .raddr (m_addr),
        .rdata (m_rdata)
    );

endmodule

`default_nettype wire

//--- bench/fetch_subsys_assert.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_subsys_assert
    import fetch_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input cache_cmd_e  c_cmd,
    input cache_resp_e c_response,
    input logic        c_reset_done,
    input e2f_t        e2f,
    input f2e_t        f2e
);

    // Cache is still sweeping
    cmd_after_sweep: assert property (
        @(posedge clk) disable iff (!rst_n)
        !c_reset_done |-> (c_cmd == CMD_NONE)
    ) else $error("cache command issued before the sweep ended");

    // Error cycles never carry an instruction
    valid_without_error: assert property (
        @(posedge clk) disable iff (!rst_n)
        f2e.valid |-> (f2e.error == ERR_NONE)
    ) else $error("instruction offered together with a fetch error");

    // Offered instruction waits for execute
    pc_held_under_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (f2e.valid && !e2f.ready) |=> $stable(f2e.pc)
    ) else $error("offered pc changed while ready was low");

    // One request at a time
    no_cmd_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (c_response == RESP_WAIT) |-> (c_cmd == CMD_NONE)
    ) else $error("cache command issued while a request was in progress");

endmodule

bind fetch_unit fetch_subsys_assert i_fetch_subsys_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .c_cmd        (c_cmd),
    .c_response   (c_response),
    .c_reset_done (c_reset_done),
    .e2f          (e2f),
    .f2e          (f2e)
);

`default_nettype wire

//--- bench/fetch_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_subsys_tb
    import fetch_pkg::*;
();

    localparam string        CASES_FILE = "bench/fetch_cases.txt";
    localparam logic [31:0]  FILL_MUL   = 32'h9e37_79b1;

    logic   clk;
    logic   rst_n;
    e2f_t   e2f;
    f2e_t   f2e;
    logic   mem_we;
    addr_t  mem_waddr;
    instr_t mem_wdata;

    // Expected program image
    instr_t prog [`MEM_WORDS];

    // Cases from the file
    string      case_name [$];
    string      case_kind [$];
    int         case_count [$];
    addr_t      case_target [$];
    fetch_err_e case_err [$];

    addr_t       exp_pc;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;
    int          watchdog_cycles;

    fetch_subsys i_fetch_subsys (
        .clk       (clk),
        .rst_n     (rst_n),
        .e2f       (e2f),
        .f2e       (f2e),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

    always #4 clk = ~clk;

    function automatic instr_t fill_word(input instr_t key, input addr_t a);
        return key ^ (a * FILL_MUL);
    endfunction

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (exp !== act) begin
            $display("** Error %s instr expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("** Error %s pc expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_err(input string name, input fetch_err_e exp, input fetch_err_e act);
        if (exp !== act) begin
            $display("** Error %s error expected %s actual %s", name, exp.name(), act.name());
            test_errs++;
        end
    endtask

    // Drive on the rising edge, return at the falling edge to sample
    task automatic run_cycle(input logic rdy, input e2f_cmd_e cmd, input addr_t tgt);
        @(posedge clk);
        e2f.ready  <= rdy;
        e2f.cmd    <= cmd;
        e2f.target <= tgt;
        mem_we     <= 1'b0;
        @(negedge clk);
    endtask

    // Load port write, execute stalled meanwhile
    task automatic write_word(input addr_t a, input instr_t d);
        @(posedge clk);
        e2f.ready <= 1'b0;
        mem_we    <= 1'b1;
        mem_waddr <= a;
        mem_wdata <= d;
        prog[int'(a >> 2)] = d;
    endtask

    // Until execute takes one instruction, then compare with the image
    task automatic accept_next(input logic stall, input e2f_cmd_e cmd, input addr_t tgt,
                               input string name);
        logic rdy;
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            rdy = !(stall && (($urandom % 3) == 0));
            run_cycle(rdy, cmd, tgt);
            if (f2e.error != ERR_NONE) begin
                $display("%s saw an unexpected fetch error at pc %h", name, f2e.pc);
                test_errs++;
            end
            taken = f2e.valid && rdy;
        end
        check_addr(name, exp_pc, f2e.pc);
        check_instr(name, prog[int'(exp_pc >> 2)], f2e.instr);
        exp_pc += 4;
    endtask

    // Fault is answered right after the redirect
    // With hold set, execute is stalled across the error cycle and after it
    task automatic expect_error(input string name, input fetch_err_e err, input addr_t tgt,
                                input logic hold);
        do begin
            run_cycle(!hold, E2F_NONE, '0);
            if (f2e.valid) begin
                $display("%s got an instruction before the fetch error", name);
                test_errs++;
            end
        end while (f2e.error == ERR_NONE);
        check_err(name, err, f2e.error);
        check_addr(name, tgt, f2e.pc);
        if (hold) begin
            // Pending error, nothing offered and nothing reported again
            repeat (3) begin
                run_cycle(1'b0, E2F_NONE, '0);
                if (f2e.valid || (f2e.error != ERR_NONE)) begin
                    $display("%s offered output while the fetch error was pending", name);
                    test_errs++;
                end
            end
        end
    endtask

    task automatic read_cases();
        int               fd;
        int               n;
        string            line;
        logic [8*32-1:0]  tok;
        logic [8*32-1:0]  name_buf;
        logic [8*32-1:0]  kind_buf;
        logic [8*32-1:0]  err_buf;
        logic [31:0]      v0;
        logic [31:0]      v1;
        int               count;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s", CASES_FILE);
            fail_cnt++;
            return;
        end
        n = $fgets(line, fd);
        while (n != 0) begin
            n = $sscanf(line, "%s", tok);
            if ((n >= 1) && (tok != "#")) begin
                if (tok == "fill") begin
                    n = $sscanf(line, "%s %h", tok, v0);
                    for (int w = 0; w < `MEM_WORDS; w++) begin
                        prog[w] = fill_word(v0, addr_t'(w * 4));
                    end
                end else if (tok == "word") begin
                    n = $sscanf(line, "%s %h %h", tok, v0, v1);
                    prog[int'(v0 >> 2)] = v1;
                end else if (tok == "case") begin
                    n = $sscanf(line, "%s %s %s %d %h %s",
                                tok, name_buf, kind_buf, count, v0, err_buf);
                    case_name.push_back($sformatf("%0s", name_buf));
                    case_kind.push_back($sformatf("%0s", kind_buf));
                    case_count.push_back(count);
                    case_target.push_back(v0);
                    if (err_buf == "MISALIGNED") begin
                        case_err.push_back(ERR_MISALIGNED);
                    end else if (err_buf == "ACCESS_FAULT") begin
                        case_err.push_back(ERR_ACCESS_FAULT);
                    end else begin
                        case_err.push_back(ERR_NONE);
                    end
                end else begin
                    $display("Cases file has a line that cannot be read: %s", line);
                    fail_cnt++;
                end
            end
            n = $fgets(line, fd);
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int i);
        string name;
        string kind;
        addr_t a;
        name = case_name[i];
        kind = case_kind[i];
        test_errs = 0;
        if ((kind == "seq") || (kind == "back")) begin
            repeat (case_count[i]) accept_next(kind == "back", E2F_NONE, '0, name);
        end else if (kind == "branch") begin
            // Instruction in flight is taken together with the redirect
            accept_next(1'b0, E2F_BRANCH, case_target[i], name);
            exp_pc = case_target[i];
            repeat (case_count[i]) accept_next(1'b0, E2F_NONE, '0, name);
        end else if (kind == "flush") begin
            // New words behind the next pc, old copies still cached
            for (int k = 1; k <= case_count[i]; k++) begin
                a = exp_pc + addr_t'(4 * k);
                write_word(a, fill_word(case_target[i], a));
            end
            accept_next(1'b0, E2F_FLUSH, '0, name);
            repeat (case_count[i]) accept_next(1'b0, E2F_NONE, '0, name);
        end else if (kind == "fault") begin
            accept_next(1'b0, E2F_BRANCH, case_target[i], name);
            // Access faults are taken with execute stalled
            expect_error(name, case_err[i], case_target[i],
                         case_err[i] == ERR_ACCESS_FAULT);
            exp_pc = `FETCH_TRAP_VECTOR;
            repeat (case_count[i]) accept_next(1'b0, E2F_NONE, '0, name);
        end else begin
            $display("%s has an unknown kind %s", name, kind);
            test_errs++;
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", name, test_errs);
        end
    endtask

    // Ends a run that stops making progress
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h8433));
        clk             = 1'b0;
        rst_n           = 1'b0;
        e2f             = '0;
        mem_we          = 1'b0;
        mem_waddr       = '0;
        mem_wdata       = '0;
        exp_pc          = `FETCH_RESET_VECTOR;
        pass_cnt        = 0;
        fail_cnt        = 0;
        test_errs       = 0;
        watchdog_cycles = 0;
        read_cases();
        // Reset, load and sweep plus a budget per case
        watchdog_cycles = case_name.size() * 200 + `CACHE_LINES + `MEM_WORDS + 16;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        if (fail_cnt == 0) begin
            // Ready stays low until the image is in place
            for (int w = 0; w < `MEM_WORDS; w++) begin
                write_word(addr_t'(w * 4), prog[w]);
            end
            foreach (case_name[i]) run_case(i);
        end
        $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_subsys.f
+incdir+source
source/fetch_pkg.sv
source/fetch_unit.sv
source/fetch_cache.sv
source/prog_mem.sv
source/fetch_subsys.sv
bench/fetch_subsys_assert.sv
bench/fetch_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fetch_subsys_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_subsys_tb \
    -f fetch_subsys.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- bench/fetch_cases.txt
# Program image first, then the test cases, one item per line
# fill KEY sets every word to KEY xor (byte address * 9e3779b1)
# word ADDR DATA replaces the word at byte address ADDR
# case NAME KIND COUNT TARGET ERROR
#   seq and back continue the stream, back with random stalls on ready
#   branch redirects to TARGET, flush rewrites COUNT words with key TARGET
#   fault branches to TARGET, expects ERROR, then runs from the trap vector
fill 5a3c0000
word 00000040 00000013
word 00000100 00100093
word 00000104 00200113
word 00000108 00308193
word 00000200 0000006f
word 00000300 fe010113
case seq_reset      seq    16 00000000 -
case second_pass    branch 12 00000100 -
case backpressure   back   24 00000000 -
case branch_far     branch  8 00000300 -
case branch_near    branch  6 000001a4 -
case warm_lines     branch  8 00000200 -
case rewind         branch  2 00000200 -
case flush_rewrite  flush   4 a5a50000 -
case after_flush    back   10 00000000 -
case misaligned     fault   4 00000302 MISALIGNED
case out_of_range   fault   3 00000400 ACCESS_FAULT
case trap_stream    back   12 00000000 -
